/* hdl/axi_mem_pkg.sv */
/* shared widths, memory geometry, response codes and state types for the memory subsystem;
   the memory maps 256 words from address 0, and bits 1:0 of any address are ignored */
`default_nettype none

package axi_mem_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [RESP_W-1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // memory geometry, word index sits in address bits 9:2
    localparam int MEM_WORDS       = 256;
    localparam int WORD_INDEX_BITS = 8;

    // first byte address past the end of the memory
    localparam addr_t ADDR_LIMIT = addr_t'(MEM_WORDS * STRB_W);

    // holder of the shared read channel
    typedef enum logic [1:0] {
        NONE,
        IFU,
        MEMU
    } read_owner_t;

    // write tracker in the arbiter
    typedef enum logic {
        W_IDLE,
        W_BUSY
    } write_state_t;

    // slave FSM
    typedef enum logic [1:0] {
        S_IDLE,
        S_READ_RESP,
        S_WRITE_RESP
    } sram_state_t;

endpackage

`default_nettype wire

/* hdl/axi_arbiter.sv */
/* fixed-priority AXI4-Lite read arbiter, MEMU over IFU, one read in flight at a time;
   only MEMU writes, and a second aw is held off until the b of the first one completes */
`default_nettype none

module axi_arbiter
    import axi_mem_pkg::*;
(
    input  wire         clk,
    input  wire         reset,

    // IFU read address and data
    input  wire         ifu_arvalid,
    output logic        ifu_arready,
    input  wire addr_t  ifu_araddr,
    output logic        ifu_rvalid,
    input  wire         ifu_rready,
    output data_t       ifu_rdata,
    output resp_t       ifu_rresp,

    // MEMU read address and data
    input  wire         mem_arvalid,
    output logic        mem_arready,
    input  wire addr_t  mem_araddr,
    output logic        mem_rvalid,
    input  wire         mem_rready,
    output data_t       mem_rdata,
    output resp_t       mem_rresp,

    // MEMU write address, data and response
    input  wire         mem_awvalid,
    output logic        mem_awready,
    input  wire addr_t  mem_awaddr,
    input  wire         mem_wvalid,
    output logic        mem_wready,
    input  wire data_t  mem_wdata,
    input  wire strb_t  mem_wstrb,
    output logic        mem_bvalid,
    input  wire         mem_bready,
    output resp_t       mem_bresp,

    // toward the SRAM slave
    output logic        sram_arvalid,
    input  wire         sram_arready,
    output addr_t       sram_araddr,
    input  wire         sram_rvalid,
    output logic        sram_rready,
    input  wire data_t  sram_rdata,
    input  wire resp_t  sram_rresp,
    output logic        sram_awvalid,
    input  wire         sram_awready,
    output addr_t       sram_awaddr,
    output logic        sram_wvalid,
    input  wire         sram_wready,
    output data_t       sram_wdata,
    output strb_t       sram_wstrb,
    input  wire         sram_bvalid,
    output logic        sram_bready,
    input  wire resp_t  sram_bresp
);

    read_owner_t  read_owner;
    write_state_t write_state;

    logic r_done;
    logic b_done;
    logic aw_done;
    logic write_active;

    assign r_done  = sram_rvalid && sram_rready;
    assign b_done  = sram_bvalid && sram_bready;
    assign aw_done = mem_awvalid && mem_awready;

    // grant is registered, so a request waits at least one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            read_owner <= NONE;
        end else begin
            case (read_owner)
                NONE: begin
                    // MEMU wins a tie
                    if (mem_arvalid) begin
                        read_owner <= MEMU;
                    end else if (ifu_arvalid) begin
                        read_owner <= IFU;
                    end
                end
                IFU, MEMU: begin
                    // single beat, so the r handshake ends the grant
                    if (r_done) begin
                        read_owner <= NONE;
                    end
                end
                default: begin
                    read_owner <= NONE;
                end
            endcase
        end
    end

    // owner's ar channel and rready toward the slave
    always_comb begin
        case (read_owner)
            IFU: begin
                sram_arvalid = ifu_arvalid;
                sram_araddr  = ifu_araddr;
                sram_rready  = ifu_rready;
            end
            MEMU: begin
                sram_arvalid = mem_arvalid;
                sram_araddr  = mem_araddr;
                sram_rready  = mem_rready;
            end
            default: begin
                sram_arvalid = 1'b0;
                sram_araddr  = '0;
                sram_rready  = 1'b0;
            end
        endcase
    end

    // return path, only the owner sees ready and response
    assign ifu_arready = (read_owner == IFU) && sram_arready;
    assign ifu_rvalid  = (read_owner == IFU) && sram_rvalid;
    assign ifu_rdata   = (read_owner == IFU) ? sram_rdata : '0;
    assign ifu_rresp   = (read_owner == IFU) ? sram_rresp : RESP_OKAY;

    assign mem_arready = (read_owner == MEMU) && sram_arready;
    assign mem_rvalid  = (read_owner == MEMU) && sram_rvalid;
    assign mem_rdata   = (read_owner == MEMU) ? sram_rdata : '0;
    assign mem_rresp   = (read_owner == MEMU) ? sram_rresp : RESP_OKAY;

    // write tracker, open from the aw transfer until the b transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            write_state <= W_IDLE;
        end else begin
            case (write_state)
                W_IDLE: begin
                    if (aw_done) begin
                        write_state <= W_BUSY;
                    end
                end
                W_BUSY: begin
                    if (b_done) begin
                        write_state <= W_IDLE;
                    end
                end
                default: begin
                    write_state <= W_IDLE;
                end
            endcase
        end
    end

    // no second aw while one is outstanding
    assign sram_awvalid = mem_awvalid && (write_state == W_IDLE);
    assign mem_awready  = sram_awready && (write_state == W_IDLE);

    // address only while a write is requested or open
    assign write_active = mem_awvalid || (write_state == W_BUSY);
    assign sram_awaddr  = write_active ? mem_awaddr : '0;

    // w and b are not shared
    assign sram_wvalid = mem_wvalid;
    assign sram_wdata  = mem_wdata;
    assign sram_wstrb  = mem_wstrb;
    assign mem_wready  = sram_wready;
    assign mem_bvalid  = sram_bvalid;
    assign mem_bresp   = sram_bresp;
    assign sram_bready = mem_bready;

    // a stalled response must reach the master that issued it
    owner_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        (sram_rvalid && !sram_rready) |=> $stable(read_owner)
    ) else $error("read owner changed under a stalled response");

    // a slave response goes to exactly one master
    one_rvalid_a: assert property (
        @(posedge clk) disable iff (reset)
        sram_rvalid |-> (ifu_rvalid != mem_rvalid)
    ) else $error("read response not routed to exactly one master");

    no_second_aw_a: assert property (
        @(posedge clk) disable iff (reset)
        aw_done |=> !mem_awready
    ) else $error("aw accepted while a write is open");

endmodule

`default_nettype wire

/* hdl/axi_sram_slave.sv */
/* AXI4-Lite SRAM slave, 256 x 32 bit, one transaction at a time with reads first;
   addresses from 1024 up get SLVERR and never write, the memory has no reset */
`default_nettype none

module axi_sram_slave
    import axi_mem_pkg::*;
(
    input  wire         clk,
    input  wire         reset,

    input  wire         arvalid,
    output logic        arready,
    input  wire addr_t  araddr,
    output logic        rvalid,
    input  wire         rready,
    output data_t       rdata,
    output resp_t       rresp,

    input  wire         awvalid,
    output logic        awready,
    input  wire addr_t  awaddr,
    input  wire         wvalid,
    output logic        wready,
    input  wire data_t  wdata,
    input  wire strb_t  wstrb,
    output logic        bvalid,
    input  wire         bready,
    output resp_t       bresp
);

    data_t       mem [MEM_WORDS];
    sram_state_t state;

    logic  aw_held;
    logic  w_held;
    addr_t aw_addr_q;
    data_t wdata_q;
    strb_t wstrb_q;
    data_t rdata_q;
    resp_t rresp_q;
    resp_t bresp_q;

    logic  ar_fire;
    logic  aw_fire;
    logic  w_fire;
    logic  write_go;
    addr_t wr_addr;
    data_t wr_data;
    strb_t wr_strb;
    logic  rd_in_range;
    logic  wr_in_range;
    logic [WORD_INDEX_BITS-1:0] rd_index;
    logic [WORD_INDEX_BITS-1:0] wr_index;

    // reads take the idle slot before any write beat
    assign arready = (state == S_IDLE);
    assign awready = (state == S_IDLE) && !arvalid && !aw_held;
    assign wready  = (state == S_IDLE) && !arvalid && !w_held;

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // the later of the two beats completes the write
    assign write_go = (state == S_IDLE) && !arvalid
                    && (aw_held || aw_fire) && (w_held || w_fire);

    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? wdata_q : wdata;
    assign wr_strb = w_held ? wstrb_q : wstrb;

    assign rd_in_range = araddr < ADDR_LIMIT;
    assign wr_in_range = wr_addr < ADDR_LIMIT;
    assign rd_index    = araddr[WORD_INDEX_BITS+1:2];
    assign wr_index    = wr_addr[WORD_INDEX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ar_fire) begin
                        state <= S_READ_RESP;
                    end else if (write_go) begin
                        state <= S_WRITE_RESP;
                    end
                end
                S_READ_RESP: begin
                    if (rready) begin
                        state <= S_IDLE;
                    end
                end
                S_WRITE_RESP: begin
                    if (bready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase

            if (write_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_held <= 1'b1;
                end
                if (w_fire) begin
                    w_held <= 1'b1;
                end
            end
        end
    end

    // beats parked until their partner arrives, responses held until taken
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= awaddr;
        end
        if (w_fire) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (ar_fire) begin
            rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (write_go) begin
            bresp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // storage, byte lanes under the strobe mask
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_q <= rd_in_range ? mem[rd_index] : '0;
        end
        if (write_go && wr_in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    assign rvalid = (state == S_READ_RESP);
    assign rdata  = rdata_q;
    assign rresp  = rresp_q;
    assign bvalid = (state == S_WRITE_RESP);
    assign bresp  = bresp_q;

    r_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        (rvalid && !rready) |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else $error("read response dropped or changed before rready");

    b_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        (bvalid && !bready) |=> bvalid && $stable(bresp)
    ) else $error("write response dropped or changed before bready");

endmodule

`default_nettype wire

/* hdl/axi_mem_subsystem.sv */
/* memory side of the core: IFU and MEMU share one SRAM slave through the arbiter;
   expect one cycle of grant latency on every read */
`default_nettype none

module axi_mem_subsystem
    import axi_mem_pkg::*;
(
    input  wire         clk,
    input  wire         reset,

    input  wire         ifu_arvalid,
    output logic        ifu_arready,
    input  wire addr_t  ifu_araddr,
    output logic        ifu_rvalid,
    input  wire         ifu_rready,
    output data_t       ifu_rdata,
    output resp_t       ifu_rresp,

    input  wire         mem_arvalid,
    output logic        mem_arready,
    input  wire addr_t  mem_araddr,
    output logic        mem_rvalid,
    input  wire         mem_rready,
    output data_t       mem_rdata,
    output resp_t       mem_rresp,

    input  wire         mem_awvalid,
    output logic        mem_awready,
    input  wire addr_t  mem_awaddr,
    input  wire         mem_wvalid,
    output logic        mem_wready,
    input  wire data_t  mem_wdata,
    input  wire strb_t  mem_wstrb,
    output logic        mem_bvalid,
    input  wire         mem_bready,
    output resp_t       mem_bresp
);

    // arbiter to slave
    logic  sram_arvalid;
    logic  sram_arready;
    addr_t sram_araddr;
    logic  sram_rvalid;
    logic  sram_rready;
    data_t sram_rdata;
    resp_t sram_rresp;
    logic  sram_awvalid;
    logic  sram_awready;
    addr_t sram_awaddr;
    logic  sram_wvalid;
    logic  sram_wready;
    data_t sram_wdata;
    strb_t sram_wstrb;
    logic  sram_bvalid;
    logic  sram_bready;
    resp_t sram_bresp;

    axi_arbiter axi_arbiter_i (
        .clk          (clk),
        .reset        (reset),
        .ifu_arvalid  (ifu_arvalid),
        .ifu_arready  (ifu_arready),
        .ifu_araddr   (ifu_araddr),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rready   (ifu_rready),
        .ifu_rdata    (ifu_rdata),
        .ifu_rresp    (ifu_rresp),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_araddr   (mem_araddr),
        .mem_rvalid   (mem_rvalid),
        .mem_rready   (mem_rready),
        .mem_rdata    (mem_rdata),
        .mem_rresp    (mem_rresp),
        .mem_awvalid  (mem_awvalid),
        .mem_awready  (mem_awready),
        .mem_awaddr   (mem_awaddr),
        .mem_wvalid   (mem_wvalid),
        .mem_wready   (mem_wready),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_bvalid   (mem_bvalid),
        .mem_bready   (mem_bready),
        .mem_bresp    (mem_bresp),
        .sram_arvalid (sram_arvalid),
        .sram_arready (sram_arready),
        .sram_araddr  (sram_araddr),
        .sram_rvalid  (sram_rvalid),
        .sram_rready  (sram_rready),
        .sram_rdata   (sram_rdata),
        .sram_rresp   (sram_rresp),
        .sram_awvalid (sram_awvalid),
        .sram_awready (sram_awready),
        .sram_awaddr  (sram_awaddr),
        .sram_wvalid  (sram_wvalid),
        .sram_wready  (sram_wready),
        .sram_wdata   (sram_wdata),
        .sram_wstrb   (sram_wstrb),
        .sram_bvalid  (sram_bvalid),
        .sram_bready  (sram_bready),
        .sram_bresp   (sram_bresp)
    );

    axi_sram_slave axi_sram_slave_i (
        .clk     (clk),
        .reset   (reset),
        .arvalid (sram_arvalid),
        .arready (sram_arready),
        .araddr  (sram_araddr),
        .rvalid  (sram_rvalid),
        .rready  (sram_rready),
        .rdata   (sram_rdata),
        .rresp   (sram_rresp),
        .awvalid (sram_awvalid),
        .awready (sram_awready),
        .awaddr  (sram_awaddr),
        .wvalid  (sram_wvalid),
        .wready  (sram_wready),
        .wdata   (sram_wdata),
        .wstrb   (sram_wstrb),
        .bvalid  (sram_bvalid),
        .bready  (sram_bready),
        .bresp   (sram_bresp)
    );

endmodule

`default_nettype wire

/* tests/tb_axi_mem_checker.sv */
/* watches the top-level ports and checks every response against a shadow memory;
   reads are expected only at words that were written before */
`default_nettype none

module tb_axi_mem_checker
    import axi_mem_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        ifu_arvalid,
    input  wire        ifu_arready,
    input  wire addr_t ifu_araddr,
    input  wire        ifu_rvalid,
    input  wire        ifu_rready,
    input  wire data_t ifu_rdata,
    input  wire resp_t ifu_rresp,
    input  wire        mem_arvalid,
    input  wire        mem_arready,
    input  wire addr_t mem_araddr,
    input  wire        mem_rvalid,
    input  wire        mem_rready,
    input  wire data_t mem_rdata,
    input  wire resp_t mem_rresp,
    input  wire        mem_awvalid,
    input  wire        mem_awready,
    input  wire addr_t mem_awaddr,
    input  wire        mem_wvalid,
    input  wire        mem_wready,
    input  wire data_t mem_wdata,
    input  wire strb_t mem_wstrb,
    input  wire        mem_bvalid,
    input  wire        mem_bready,
    input  wire resp_t mem_bresp,
    output int         errors
);

    localparam addr_t MEM_BYTES = addr_t'(MEM_WORDS * 4);

    data_t shadow [MEM_WORDS];
    addr_t ifu_addr_q;
    addr_t mem_addr_q;
    addr_t aw_addr_q;
    data_t w_data_q;
    strb_t w_strb_q;
    logic  ifu_pending, mem_pending, aw_pending;
    logic  ifu_stall, mem_stall, b_stall;
    data_t ifu_data_last, mem_data_last;
    resp_t ifu_resp_last, mem_resp_last, b_resp_last;

    initial errors = 0;

    // out of range gives SLVERR, in range the merged shadow word
    function automatic void expected_read(input addr_t addr, output data_t data,
                                          output resp_t resp);
        if (addr >= MEM_BYTES) begin
            data = '0;
            resp = RESP_SLVERR;
        end else begin
            data = shadow[addr[9:2]];
            resp = RESP_OKAY;
        end
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic complain(input string what);
        $display("error: %s at %0t", what, $time);
        errors++;
    endtask

    task automatic check_read(input string master, input addr_t addr, input data_t data,
                              input resp_t resp);
        data_t exp_data;
        resp_t exp_resp;
        expected_read(addr, exp_data, exp_resp);
        compare({master, "_rresp"}, exp_resp, resp);
        // data of an error response carries no meaning
        if (exp_resp == RESP_OKAY) begin
            compare({master, "_rdata"}, exp_data, data);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            ifu_pending = 1'b0;
            mem_pending = 1'b0;
            aw_pending  = 1'b0;
            ifu_stall   = 1'b0;
            mem_stall   = 1'b0;
            b_stall     = 1'b0;
        end else begin
            if (ifu_rvalid && mem_rvalid) begin
                complain("ifu_rvalid and mem_rvalid high in the same cycle");
            end

            // responses stalled last cycle must still be there, unchanged
            if (ifu_stall) begin
                if (!ifu_rvalid) begin
                    complain("ifu_rvalid dropped before ifu_rready");
                end
                compare("ifu_rdata", ifu_data_last, ifu_rdata);
                compare("ifu_rresp", ifu_resp_last, ifu_rresp);
            end
            if (mem_stall) begin
                if (!mem_rvalid) begin
                    complain("mem_rvalid dropped before mem_rready");
                end
                compare("mem_rdata", mem_data_last, mem_rdata);
                compare("mem_rresp", mem_resp_last, mem_rresp);
            end
            if (b_stall) begin
                if (!mem_bvalid) begin
                    complain("mem_bvalid dropped before mem_bready");
                end
                compare("mem_bresp", b_resp_last, mem_bresp);
            end

            if (ifu_arvalid && ifu_arready) begin
                if (ifu_pending) begin
                    complain("second IFU read accepted before its response");
                end
                ifu_pending = 1'b1;
                ifu_addr_q  = ifu_araddr;
            end
            if (ifu_rvalid && ifu_rready) begin
                if (!ifu_pending) begin
                    complain("IFU read response without a read");
                end else begin
                    check_read("ifu", ifu_addr_q, ifu_rdata, ifu_rresp);
                end
                ifu_pending = 1'b0;
            end

            if (mem_arvalid && mem_arready) begin
                if (mem_pending) begin
                    complain("second MEMU read accepted before its response");
                end
                mem_pending = 1'b1;
                mem_addr_q  = mem_araddr;
            end
            if (mem_rvalid && mem_rready) begin
                if (!mem_pending) begin
                    complain("MEMU read response without a read");
                end else begin
                    check_read("mem", mem_addr_q, mem_rdata, mem_rresp);
                end
                mem_pending = 1'b0;
            end

            // write beats may arrive in either order before the b transfer
            if (mem_awvalid && mem_awready) begin
                if (aw_pending) begin
                    complain("second write address accepted before its response");
                end
                aw_pending = 1'b1;
                aw_addr_q  = mem_awaddr;
            end
            if (mem_wvalid && mem_wready) begin
                w_data_q = mem_wdata;
                w_strb_q = mem_wstrb;
            end
            if (mem_bvalid && mem_bready) begin
                if (!aw_pending) begin
                    complain("write response without a write");
                end else if (aw_addr_q < MEM_BYTES) begin
                    compare("mem_bresp", RESP_OKAY, mem_bresp);
                    shadow[aw_addr_q[9:2]] = merge_bytes(shadow[aw_addr_q[9:2]], w_data_q,
                                                         w_strb_q);
                end else begin
                    compare("mem_bresp", RESP_SLVERR, mem_bresp);
                end
                aw_pending = 1'b0;
            end

            ifu_stall     = ifu_rvalid && !ifu_rready;
            ifu_data_last = ifu_rdata;
            ifu_resp_last = ifu_rresp;
            mem_stall     = mem_rvalid && !mem_rready;
            mem_data_last = mem_rdata;
            mem_resp_last = mem_rresp;
            b_stall       = mem_bvalid && !mem_bready;
            b_resp_last   = mem_bresp;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_axi_mem_subsystem.sv */
/* drives IFU and MEMU traffic with random data and random rready/bready gaps;
   every wait gives up after TIMEOUT cycles and counts as an error */
`default_nettype none

module tb_axi_mem_subsystem
    import axi_mem_pkg::*;
();

    localparam int TIMEOUT    = 100;
    localparam int FILL_WORDS = 32;

    logic  clk;
    logic  reset;
    logic  ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    addr_t ifu_araddr;
    data_t ifu_rdata;
    resp_t ifu_rresp;
    logic  mem_arvalid, mem_arready, mem_rvalid, mem_rready;
    addr_t mem_araddr;
    data_t mem_rdata;
    resp_t mem_rresp;
    logic  mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
    addr_t mem_awaddr;
    data_t mem_wdata;
    strb_t mem_wstrb;
    resp_t mem_bresp;
    int    seed;
    int    stim_errors;
    int    check_errors;

    axi_mem_subsystem axi_mem_subsystem_i (.*);

    tb_axi_mem_checker checker_i (.*, .errors(check_errors));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic data_t random_word();
        return data_t'($random(seed));
    endfunction

    // one of the filled words 0..31, with random bits 1:0
    function automatic addr_t written_addr();
        int r;
        r = $random(seed);
        return addr_t'({r[4:0], r[9:8]});
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
        stim_errors++;
    endtask

    task automatic read_word(input logic from_ifu, input addr_t addr);
        int   cycles;
        logic done;
        if (from_ifu) begin
            ifu_arvalid <= 1'b1;
            ifu_araddr  <= addr;
        end else begin
            mem_arvalid <= 1'b1;
            mem_araddr  <= addr;
        end
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            done = from_ifu ? ifu_arready : mem_arready;
        end while (!done && cycles < TIMEOUT);
        if (from_ifu) begin
            ifu_arvalid <= 1'b0;
        end else begin
            mem_arvalid <= 1'b0;
        end
        if (!done) begin
            report_timeout(from_ifu ? "ifu_arready" : "mem_arready");
        end
        // random rready gaps
        cycles = 0;
        do begin
            if (from_ifu) begin
                ifu_rready <= random_bit();
            end else begin
                mem_rready <= random_bit();
            end
            @(posedge clk);
            cycles++;
            done = from_ifu ? (ifu_rvalid && ifu_rready) : (mem_rvalid && mem_rready);
        end while (!done && cycles < TIMEOUT);
        ifu_rready <= 1'b0;
        mem_rready <= 1'b0;
        if (!done) begin
            report_timeout(from_ifu ? "IFU read response" : "MEMU read response");
        end
    endtask

    task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
        int   cycles;
        logic aw_open;
        logic w_open;
        logic done;
        mem_awvalid <= 1'b1;
        mem_awaddr  <= addr;
        mem_wvalid  <= 1'b1;
        mem_wdata   <= data;
        mem_wstrb   <= strb;
        aw_open = 1'b1;
        w_open  = 1'b1;
        cycles  = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (aw_open && mem_awready) begin
                aw_open = 1'b0;
                mem_awvalid <= 1'b0;
            end
            if (w_open && mem_wready) begin
                w_open = 1'b0;
                mem_wvalid <= 1'b0;
            end
        end while ((aw_open || w_open) && cycles < TIMEOUT);
        if (aw_open || w_open) begin
            mem_awvalid <= 1'b0;
            mem_wvalid  <= 1'b0;
            report_timeout("write address or data handshake");
        end
        cycles = 0;
        do begin
            mem_bready <= random_bit();
            @(posedge clk);
            cycles++;
            done = mem_bvalid && mem_bready;
        end while (!done && cycles < TIMEOUT);
        mem_bready <= 1'b0;
        if (!done) begin
            report_timeout("write response");
        end
    endtask

    // on a tied request the MEMU must be answered first
    task automatic check_memu_first();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!ifu_rvalid && !mem_rvalid && cycles < TIMEOUT);
        if (ifu_rvalid) begin
            $display("error: IFU answered before MEMU on a tied read at %0t", $time);
            stim_errors++;
        end else if (!mem_rvalid) begin
            report_timeout("read response on a tied request");
        end
    endtask

    initial begin
        addr_t addr;
        addr_t tied_addr;
        seed        = 32'h783cf22e;
        stim_errors = 0;
        reset       = 1'b1;
        ifu_arvalid = 1'b0;
        ifu_araddr  = '0;
        ifu_rready  = 1'b0;
        mem_arvalid = 1'b0;
        mem_araddr  = '0;
        mem_rready  = 1'b0;
        mem_awvalid = 1'b0;
        mem_awaddr  = '0;
        mem_wvalid  = 1'b0;
        mem_wdata   = '0;
        mem_wstrb   = '0;
        mem_bready  = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // fill words 0..31 and the top word
        for (int i = 0; i < FILL_WORDS; i++) begin
            write_word(addr_t'(i * 4), random_word(), 4'hf);
        end
        write_word(addr_t'(1020), random_word(), 4'hf);
        write_word(addr_t'(8), random_word(), 4'hf);
        read_word(1'b0, addr_t'(8));

        // IFU and MEMU reads mixed with MEMU writes
        for (int i = 0; i < 24; i++) begin
            read_word(random_bit(), written_addr());
            if (i % 6 == 5) begin
                write_word(written_addr(), random_word(), 4'hf);
            end
        end

        for (int i = 0; i < 16; i++) begin
            addr = written_addr();
            write_word(addr, random_word(), strb_t'($random(seed)));
            read_word(random_bit(), addr);
        end

        // out of range, low bits of 1032 would alias word 2
        write_word(addr_t'(1024), random_word(), 4'hf);
        write_word(addr_t'(1032), random_word(), 4'hf);
        write_word(32'hffff_fffc, random_word(), 4'h3);
        read_word(1'b0, addr_t'(1024));
        read_word(1'b1, 32'h0001_0004);
        for (int i = 0; i < FILL_WORDS; i++) begin
            read_word(i[0], addr_t'(i * 4));
        end
        read_word(1'b1, addr_t'(1020));

        for (int i = 0; i < 4; i++) begin
            addr      = written_addr();
            tied_addr = written_addr();
            fork
                read_word(1'b1, addr);
                read_word(1'b0, tied_addr);
                check_memu_first();
            join
        end

        repeat (4) @(posedge clk);
        $display("errors: %0d in checks, %0d in stimulus", check_errors, stim_errors);
        if (check_errors + stim_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* axi_mem_subsystem.f */
hdl/axi_mem_pkg.sv
hdl/axi_arbiter.sv
hdl/axi_sram_slave.sv
hdl/axi_mem_subsystem.sv
tests/tb_axi_mem_checker.sv
tests/tb_axi_mem_subsystem.sv
